// File: Makefile
TOP := renkon_top_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f renkon_top.f --Mdir obj_dir -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: bench/renkon_props.sv
`default_nettype none

module renkon_props
  ( input wire        clk
  , input wire        xrst
  , input wire        req_edge
  , input wire  [1:0] state
  , input wire        ack
  , input wire        breg_we
  , input wire        mac_en
  , input wire        ser_we
  );
  timeunit 1ns;
  timeprecision 100ps;

  // ====================
  // handshake
  // ====================

  ack_drops_on_start: assert property (@(posedge clk) disable iff (!xrst)
    state == renkon_pkg::S_WAIT && req_edge |=> !ack)
    else $error("ack still high one cycle after a start request");

  // ====================
  // datapath strobes
  // ====================

  // bias load and MAC never overlap
  strobes_exclusive: assert property (@(posedge clk) disable iff (!xrst)
    !(breg_we && mac_en))
    else $error("breg_we and mac_en high in the same cycle");

  write_in_output: assert property (@(posedge clk) disable iff (!xrst)
    ser_we |-> state == renkon_pkg::S_OUTPUT)
    else $error("serializer write outside the output phase");

endmodule

`default_nettype wire

// File: bench/renkon_top_tb.sv
`default_nettype none

module renkon_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 10;
  localparam int MAX_OUT      = 16;
  localparam int MAX_IN       = 64;

  // layer sizes of each run
  localparam int T1_IN   = 8;
  localparam int T1_OUT  = 4;
  localparam int T2_IN   = 6;
  localparam int T2_OUT  = 4;
  localparam int T3_IN   = 5;
  localparam int T3_OUT  = 6;
  localparam int T4_IN   = 4;
  localparam int T4_OUT  = 4;
  localparam int T5A_IN  = 7;
  localparam int T5A_OUT = 4;
  localparam int T5B_IN  = 3;
  localparam int T5B_OUT = 8;

  function automatic int run_cost(int ti, int to);
    return ((to + renkon_pkg::N_CORE - 1) / renkon_pkg::N_CORE)
           * (ti + renkon_pkg::N_CORE + 4);
  endfunction

  localparam int RUN_BUDGET = 20 * (run_cost(T1_IN, T1_OUT) + run_cost(T2_IN, T2_OUT)
                            + run_cost(T3_IN, T3_OUT) + run_cost(T4_IN, T4_OUT)
                            + run_cost(T5A_IN, T5A_OUT) + run_cost(T5B_IN, T5B_OUT));

  logic                                     clk;
  logic                                     xrst;
  logic                                     req;
  logic                                     relu_en;
  logic        [renkon_pkg::LWIDTH-1:0]     total_in;
  logic        [renkon_pkg::LWIDTH-1:0]     total_out;
  logic        [renkon_pkg::IMGSIZE-1:0]    in_offset;
  logic        [renkon_pkg::IMGSIZE-1:0]    out_offset;
  logic        [renkon_pkg::NETSIZE-1:0]    net_offset;
  logic                                     net_we;
  logic        [renkon_pkg::CORE_LOG-1:0]   net_sel;
  logic        [renkon_pkg::NETSIZE-1:0]    net_addr;
  logic signed [renkon_pkg::DWIDTH-1:0]     net_wdata;
  logic                                     img_we;
  logic        [renkon_pkg::IMGSIZE-1:0]    img_addr;
  logic signed [renkon_pkg::DWIDTH-1:0]     img_wdata;
  logic        [renkon_pkg::IMGSIZE-1:0]    img_raddr;
  wire  signed [renkon_pkg::DWIDTH-1:0]     img_rdata;
  wire                                      ack;
  wire         [1:0]                        core_state;

  // model storage, one row of weights per output
  int wt     [0:MAX_OUT-1][0:MAX_IN-1];
  int bias_v [0:MAX_OUT-1];
  int xin    [0:MAX_IN-1];

  renkon_top renkon_top_inst (.*);

  bind renkon_ctrl renkon_props props_inst
    ( .clk      (clk)
    , .xrst     (xrst)
    , .req_edge (req_edge)
    , .state    (state)
    , .ack      (ack)
    , .breg_we  (breg_we)
    , .mac_en   (mac_en)
    , .ser_we   (renkon_top_tb.renkon_top_inst.ser_we)
    );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ====================
  // failure reporting
  // ====================

  task automatic report_mismatch(string test, logic signed [15:0] expected,
                                 logic signed [15:0] actual);
    $display("ERR %s expected %0d actual %0d", test, expected, actual);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic abort_run(string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  initial begin
    repeat (RESET_CYCLES + RUN_BUDGET) @(posedge clk);
    abort_run($sformatf("timeout, regression still running after %0d cycles",
                        RESET_CYCLES + RUN_BUDGET));
  end

  // ====================
  // host access
  // ====================

  task automatic write_net(int core, int addr, int data);
    @(negedge clk);
    net_we    = 1'b1;
    net_sel   = renkon_pkg::CORE_LOG'(core);
    net_addr  = renkon_pkg::NETSIZE'(addr);
    net_wdata = renkon_pkg::DWIDTH'(data);
    @(negedge clk);
    net_we    = 1'b0;
  endtask

  task automatic write_img(int addr, int data);
    @(negedge clk);
    img_we    = 1'b1;
    img_addr  = renkon_pkg::IMGSIZE'(addr);
    img_wdata = renkon_pkg::DWIDTH'(data);
    @(negedge clk);
    img_we    = 1'b0;
  endtask

  // registered read, data valid one cycle later
  task automatic read_img(int addr, output logic signed [15:0] data);
    @(negedge clk);
    img_raddr = renkon_pkg::IMGSIZE'(addr);
    @(negedge clk);
    data = img_rdata;
  endtask

  task automatic load_network(int net_off, int ti, int to);
    int base;
    for (int o = 0; o < to; o++) begin
      base = net_off + (o / renkon_pkg::N_CORE) * (ti + 1);
      for (int j = 0; j < ti; j++)
        write_net(o % renkon_pkg::N_CORE, base + j, wt[o][j]);
      write_net(o % renkon_pkg::N_CORE, base + ti, bias_v[o]);
    end
  endtask

  task automatic load_inputs(int in_off, int ti);
    for (int j = 0; j < ti; j++)
      write_img(in_off + j, xin[j]);
  endtask

  task automatic run_layer(string test, int ti, int to, bit relu, int in_off,
                           int out_off, int net_off);
    @(negedge clk);
    total_in   = renkon_pkg::LWIDTH'(ti);
    total_out  = renkon_pkg::LWIDTH'(to);
    relu_en    = relu;
    in_offset  = renkon_pkg::IMGSIZE'(in_off);
    out_offset = renkon_pkg::IMGSIZE'(out_off);
    net_offset = renkon_pkg::NETSIZE'(net_off);
    req        = 1'b1;
    @(negedge clk);
    req        = 1'b0;
    assert (ack == 1'b0)
      else abort_run($sformatf("%s: ack did not drop after req", test));
    // start edge moves the phase straight to the bias fetch
    assert (core_state == renkon_pkg::S_NETWORK)
      else report_mismatch(test, renkon_pkg::S_NETWORK, core_state);
    while (ack !== 1'b1)
      @(negedge clk);
    assert (core_state == renkon_pkg::S_WAIT)
      else report_mismatch(test, renkon_pkg::S_WAIT, core_state);
  endtask

  // ====================
  // reference model
  // ====================

  function automatic int rand_signed(int lim);
    return int'($urandom % (2 * lim + 1)) - lim;
  endfunction

  function automatic logic signed [15:0] marker(int addr);
    return renkon_pkg::DWIDTH'(32'h5a00 + addr * 37);
  endfunction

  // bias at product scale, then floor shift, clamp and relu
  function automatic logic signed [15:0] model_out(int o, int ti, bit relu);
    longint acc;
    acc = longint'(bias_v[o]) * (longint'(1) << renkon_pkg::QBITS);
    for (int j = 0; j < ti; j++)
      acc += longint'(wt[o][j]) * longint'(xin[j]);
    acc = acc >>> renkon_pkg::QBITS;
    if (acc > 32767)
      acc = 32767;
    else if (acc < -32768)
      acc = -32768;
    if (relu && acc < 0)
      acc = 0;
    return 16'(acc);
  endfunction

  task automatic fill_random(int ti, int to, int wlim, int blim, int xlim);
    for (int o = 0; o < to; o++) begin
      for (int j = 0; j < ti; j++)
        wt[o][j] = rand_signed(wlim);
      bias_v[o] = rand_signed(blim);
    end
    for (int j = 0; j < ti; j++)
      xin[j] = rand_signed(xlim);
  endtask

  task automatic check_outputs(string test, int ti, int to, bit relu, int out_off);
    logic signed [15:0] got;
    logic signed [15:0] exp;
    for (int o = 0; o < to; o++) begin
      read_img(out_off + o, got);
      exp = model_out(o, ti, relu);
      assert (got == exp) else report_mismatch(test, exp, got);
    end
  endtask

  task automatic check_inputs(string test, int ti, int in_off);
    logic signed [15:0] got;
    for (int j = 0; j < ti; j++) begin
      read_img(in_off + j, got);
      assert (got == 16'(xin[j])) else report_mismatch(test, 16'(xin[j]), got);
    end
  endtask

  // ====================
  // directed tests
  // ====================

  task automatic test_single_pass();
    fill_random(T1_IN, T1_OUT, 8, 64, 16);
    load_network(0, T1_IN, T1_OUT);
    load_inputs(0, T1_IN);
    run_layer("test_single_pass", T1_IN, T1_OUT, 1'b0, 0, 100, 0);
    check_outputs("test_single_pass", T1_IN, T1_OUT, 1'b0, 100);
  endtask

  task automatic test_relu();
    logic signed [15:0] got;
    logic signed [15:0] exp;
    fill_random(T2_IN, T2_OUT, 4, 0, 0);
    // even outputs far below zero, odd ones well above
    for (int o = 0; o < T2_OUT; o++)
      bias_v[o] = (o % 2 == 0) ? -500 : 300;
    for (int j = 0; j < T2_IN; j++)
      xin[j] = int'($urandom % 9);
    load_network(0, T2_IN, T2_OUT);
    load_inputs(0, T2_IN);
    run_layer("test_relu", T2_IN, T2_OUT, 1'b1, 0, 120, 0);
    check_outputs("test_relu", T2_IN, T2_OUT, 1'b1, 120);
    for (int o = 0; o < T2_OUT; o++) begin
      read_img(120 + o, got);
      exp = (o % 2 == 0) ? 16'sd0 : model_out(o, T2_IN, 1'b0);
      assert (got == exp) else report_mismatch("test_relu", exp, got);
    end
  endtask

  task automatic test_partial_pass();
    logic signed [15:0] got;
    fill_random(T3_IN, T3_OUT, 8, 64, 16);
    load_network(0, T3_IN, T3_OUT);
    load_inputs(20, T3_IN);
    // words just past the last output must survive
    write_img(206, marker(206));
    write_img(207, marker(207));
    run_layer("test_partial_pass", T3_IN, T3_OUT, 1'b0, 20, 200, 0);
    check_outputs("test_partial_pass", T3_IN, T3_OUT, 1'b0, 200);
    for (int a = 206; a < 208; a++) begin
      read_img(a, got);
      assert (got == marker(a)) else report_mismatch("test_partial_pass", marker(a), got);
    end
  endtask

  task automatic test_saturate();
    logic signed [15:0] got;
    logic signed [15:0] exp;
    for (int o = 0; o < T4_OUT; o++) begin
      for (int j = 0; j < T4_IN; j++)
        wt[o][j] = (o < 2) ? 30000 : -30000;
      bias_v[o] = 0;
    end
    for (int j = 0; j < T4_IN; j++)
      xin[j] = 30000 - j * 100;
    load_network(0, T4_IN, T4_OUT);
    load_inputs(0, T4_IN);
    run_layer("test_saturate", T4_IN, T4_OUT, 1'b0, 0, 140, 0);
    check_outputs("test_saturate", T4_IN, T4_OUT, 1'b0, 140);
    for (int o = 0; o < T4_OUT; o++) begin
      read_img(140 + o, got);
      exp = (o < 2) ? 16'sh7fff : 16'sh8000;
      assert (got == exp) else report_mismatch("test_saturate", exp, got);
    end
  endtask

  task automatic test_offsets();
    fill_random(T5A_IN, T5A_OUT, 8, 64, 16);
    load_network(64, T5A_IN, T5A_OUT);
    load_inputs(300, T5A_IN);
    run_layer("test_offsets", T5A_IN, T5A_OUT, 1'b0, 300, 400, 64);
    check_outputs("test_offsets", T5A_IN, T5A_OUT, 1'b0, 400);
    check_inputs("test_offsets", T5A_IN, 300);
    // second run right after, new windows and two passes
    fill_random(T5B_IN, T5B_OUT, 8, 64, 16);
    load_network(130, T5B_IN, T5B_OUT);
    load_inputs(500, T5B_IN);
    run_layer("test_offsets", T5B_IN, T5B_OUT, 1'b1, 500, 600, 130);
    check_outputs("test_offsets", T5B_IN, T5B_OUT, 1'b1, 600);
    check_inputs("test_offsets", T5B_IN, 500);
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    void'($urandom(32'h852882cc));
    xrst       = 1'b0;
    req        = 1'b0;
    relu_en    = 1'b0;
    total_in   = '0;
    total_out  = '0;
    in_offset  = '0;
    out_offset = '0;
    net_offset = '0;
    net_we     = 1'b0;
    net_sel    = '0;
    net_addr   = '0;
    net_wdata  = '0;
    img_we     = 1'b0;
    img_addr   = '0;
    img_wdata  = '0;
    img_raddr  = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    xrst = 1'b1;
    @(negedge clk);
    test_single_pass();
    test_relu();
    test_partial_pass();
    test_saturate();
    test_offsets();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: renkon_top.f
rtl/renkon_pkg.sv
rtl/renkon_ctrl.sv
rtl/renkon_core.sv
rtl/renkon_serial.sv
rtl/renkon_img_mem.sv
rtl/renkon_top.sv
bench/renkon_props.sv
bench/renkon_top_tb.sv

// File: rtl/renkon_core.sv
`default_nettype none

module renkon_core
  #( parameter logic [renkon_pkg::CORE_LOG-1:0] core_id = '0
  )
  ( input  wire                                    clk
  , input  wire                                    xrst
  , input  wire                                    net_we
  , input  wire         [renkon_pkg::CORE_LOG-1:0] net_sel
  , input  wire         [renkon_pkg::NETSIZE-1:0]  net_waddr
  , input  wire  signed [renkon_pkg::DWIDTH-1:0]   net_wdata
  , input  wire         [renkon_pkg::NETSIZE-1:0]  net_raddr
  , input  wire                                    breg_we
  , input  wire                                    mac_en
  , input  wire                                    last_input
  , input  wire                                    relu
  , input  wire  signed [renkon_pkg::DWIDTH-1:0]   img_rdata
  , output logic signed [renkon_pkg::DWIDTH-1:0]   result
  , output logic                                   res_valid
  );

  logic signed [renkon_pkg::DWIDTH-1:0]    net_mem [0:(1<<renkon_pkg::NETSIZE)-1];
  logic signed [renkon_pkg::DWIDTH-1:0]    net_rdata;

  logic signed [2*renkon_pkg::DWIDTH-1:0]  prod;
  logic signed [renkon_pkg::ACC_WIDTH-1:0] prod_ext;
  logic signed [renkon_pkg::ACC_WIDTH-1:0] bias_ext;
  logic signed [renkon_pkg::ACC_WIDTH-1:0] acc;
  logic signed [renkon_pkg::ACC_WIDTH-1:0] acc_next;
  logic signed [renkon_pkg::ACC_WIDTH-1:0] scaled;
  logic                                    pos_ovf;
  logic                                    neg_ovf;
  logic signed [renkon_pkg::DWIDTH-1:0]    sat;
  logic signed [renkon_pkg::DWIDTH-1:0]    act;

  // ====================
  // network memory
  // ====================

  always @(posedge clk)
    if (net_we && net_sel == core_id)
      net_mem[net_waddr] <= net_wdata;

  // shared read address, one cycle latency
  always @(posedge clk)
    net_rdata <= net_mem[net_raddr];

  // ====================
  // multiply-accumulate
  // ====================

  assign prod     = net_rdata * img_rdata;
  assign prod_ext = {{(renkon_pkg::ACC_WIDTH-2*renkon_pkg::DWIDTH){prod[2*renkon_pkg::DWIDTH-1]}},
                     prod};
  // bias brought up to the product scale
  assign bias_ext = {{(renkon_pkg::ACC_WIDTH-renkon_pkg::DWIDTH-renkon_pkg::QBITS)
                       {net_rdata[renkon_pkg::DWIDTH-1]}},
                     net_rdata, {renkon_pkg::QBITS{1'b0}}};
  assign acc_next = acc + prod_ext;

  always @(posedge clk)
    if (breg_we)
      acc <= bias_ext;
    else if (mac_en)
      acc <= acc_next;

  // ====================
  // scale, saturate, relu
  // ====================

  assign scaled  = acc_next >>> renkon_pkg::QBITS;
  assign pos_ovf = !scaled[renkon_pkg::ACC_WIDTH-1]
                && |scaled[renkon_pkg::ACC_WIDTH-2:renkon_pkg::DWIDTH-1];
  assign neg_ovf = scaled[renkon_pkg::ACC_WIDTH-1]
                && !(&scaled[renkon_pkg::ACC_WIDTH-2:renkon_pkg::DWIDTH-1]);

  assign sat = pos_ovf ? {1'b0, {(renkon_pkg::DWIDTH-1){1'b1}}}
             : neg_ovf ? {1'b1, {(renkon_pkg::DWIDTH-1){1'b0}}}
             : scaled[renkon_pkg::DWIDTH-1:0];

  assign act = relu && sat[renkon_pkg::DWIDTH-1] ? '0 : sat;

  // result taken straight from the final sum
  always @(posedge clk)
    if (mac_en && last_input)
      result <= act;

  always @(posedge clk)
    if (!xrst)
      res_valid <= 1'b0;
    else
      res_valid <= mac_en && last_input;

endmodule

`default_nettype wire

// File: rtl/renkon_ctrl.sv
`default_nettype none

module renkon_ctrl
  ( input  wire                             clk
  , input  wire                             xrst
  , input  wire                             req
  , input  wire                             relu_en
  , input  wire  [renkon_pkg::LWIDTH-1:0]   total_in
  , input  wire  [renkon_pkg::LWIDTH-1:0]   total_out
  , input  wire  [renkon_pkg::IMGSIZE-1:0]  in_offset
  , input  wire  [renkon_pkg::IMGSIZE-1:0]  out_offset
  , input  wire  [renkon_pkg::NETSIZE-1:0]  net_offset
  , input  wire                             drain_end
  , output logic                            ack
  , output logic [1:0]                      core_state
  , output logic [renkon_pkg::NETSIZE-1:0]  net_raddr
  , output logic [renkon_pkg::IMGSIZE-1:0]  img_raddr
  , output logic                            breg_we
  , output logic                            mac_en
  , output logic                            last_input
  , output logic                            relu
  , output logic [renkon_pkg::IMGSIZE-1:0]  out_base
  , output logic [renkon_pkg::CORE_LOG:0]   n_valid
  );

  logic [1:0]                      state;
  logic                            req_d;
  logic                            req_edge;
  logic                            in_last;
  logic                            pass_last;

  logic [renkon_pkg::LWIDTH-1:0]   total_in_r;
  logic [renkon_pkg::LWIDTH-1:0]   total_out_r;
  logic [renkon_pkg::IMGSIZE-1:0]  in_offset_r;
  logic [renkon_pkg::IMGSIZE-1:0]  out_offset_r;

  logic [renkon_pkg::LWIDTH-1:0]   count_in;
  logic [renkon_pkg::LWIDTH-1:0]   count_out;
  logic [renkon_pkg::LWIDTH-1:0]   out_remain;
  logic [renkon_pkg::NETSIZE-1:0]  net_ptr;

  // ====================
  // phase control
  // ====================

  assign req_edge   = req && !req_d;
  assign in_last    = count_in == total_in_r - 1'b1;
  assign out_remain = total_out_r - count_out;
  // fewer than one full pass left after this one
  assign pass_last  = out_remain <= renkon_pkg::LWIDTH'(renkon_pkg::N_CORE);

  assign core_state = state;

  always @(posedge clk)
    if (!xrst)
      req_d <= 1'b0;
    else
      req_d <= req;

  always @(posedge clk)
    if (!xrst) begin
      state     <= renkon_pkg::S_WAIT;
      count_in  <= '0;
      count_out <= '0;
      net_ptr   <= '0;
    end
    else begin
      case (state)
        renkon_pkg::S_WAIT:
          if (req_edge) begin
            state     <= renkon_pkg::S_NETWORK;
            count_in  <= '0;
            count_out <= '0;
            net_ptr   <= net_offset;
          end
        // bias fetch only
        renkon_pkg::S_NETWORK:
          state <= renkon_pkg::S_INPUT;
        renkon_pkg::S_INPUT:
          if (in_last) begin
            state    <= renkon_pkg::S_OUTPUT;
            count_in <= '0;
            // step over the bias word of this pass
            net_ptr  <= net_ptr + renkon_pkg::NETSIZE'(2);
          end
          else begin
            count_in <= count_in + 1'b1;
            net_ptr  <= net_ptr + 1'b1;
          end
        renkon_pkg::S_OUTPUT:
          if (drain_end) begin
            if (pass_last) begin
              state <= renkon_pkg::S_WAIT;
            end
            else begin
              state     <= renkon_pkg::S_NETWORK;
              count_out <= count_out + renkon_pkg::LWIDTH'(renkon_pkg::N_CORE);
            end
          end
        default:
          state <= renkon_pkg::S_WAIT;
      endcase
    end

  always @(posedge clk)
    if (!xrst)
      ack <= 1'b1;
    else if (state == renkon_pkg::S_WAIT && req_edge)
      ack <= 1'b0;
    else if (state == renkon_pkg::S_OUTPUT && drain_end && pass_last)
      ack <= 1'b1;

  // ====================
  // layer parameters
  // ====================

  always @(posedge clk)
    if (!xrst) begin
      total_in_r   <= '0;
      total_out_r  <= '0;
      in_offset_r  <= '0;
      out_offset_r <= '0;
      relu         <= 1'b0;
    end
    else if (state == renkon_pkg::S_WAIT && req_edge) begin
      total_in_r   <= total_in;
      total_out_r  <= total_out;
      in_offset_r  <= in_offset;
      out_offset_r <= out_offset;
      relu         <= relu_en;
    end

  // ====================
  // read addresses and strobes
  // ====================

  // bias sits right after the weights of a pass
  assign net_raddr = state == renkon_pkg::S_NETWORK
                   ? net_ptr + total_in_r[renkon_pkg::NETSIZE-1:0]
                   : net_ptr;

  assign img_raddr = in_offset_r + count_in;

  // strobes trail the addresses by the memory latency
  always @(posedge clk)
    if (!xrst) begin
      breg_we    <= 1'b0;
      mac_en     <= 1'b0;
      last_input <= 1'b0;
    end
    else begin
      breg_we    <= state == renkon_pkg::S_NETWORK;
      mac_en     <= state == renkon_pkg::S_INPUT;
      last_input <= state == renkon_pkg::S_INPUT && in_last;
    end

  // write-back window of the current pass
  assign out_base = out_offset_r + count_out;
  assign n_valid  = pass_last
                  ? out_remain[renkon_pkg::CORE_LOG:0]
                  : (renkon_pkg::CORE_LOG+1)'(renkon_pkg::N_CORE);

endmodule

`default_nettype wire

// File: rtl/renkon_img_mem.sv
`default_nettype none

module renkon_img_mem
  ( input  wire                                   clk
  , input  wire         [renkon_pkg::IMGSIZE-1:0] raddr
  , input  wire         [renkon_pkg::IMGSIZE-1:0] host_raddr
  , input  wire                                   we
  , input  wire         [renkon_pkg::IMGSIZE-1:0] waddr
  , input  wire  signed [renkon_pkg::DWIDTH-1:0]  wdata
  , input  wire                                   host_we
  , input  wire         [renkon_pkg::IMGSIZE-1:0] host_waddr
  , input  wire  signed [renkon_pkg::DWIDTH-1:0]  host_wdata
  , output logic signed [renkon_pkg::DWIDTH-1:0]  rdata
  , output logic signed [renkon_pkg::DWIDTH-1:0]  host_rdata
  );

  logic signed [renkon_pkg::DWIDTH-1:0] mem [0:(1<<renkon_pkg::IMGSIZE)-1];

  // ====================
  // write port
  // ====================

  // serializer wins over the host
  always @(posedge clk)
    if (we)
      mem[waddr] <= wdata;
    else if (host_we)
      mem[host_waddr] <= host_wdata;

  // ====================
  // read ports
  // ====================

  // controller side, feeds every core
  always @(posedge clk)
    rdata <= mem[raddr];

  always @(posedge clk)
    host_rdata <= mem[host_raddr];

endmodule

`default_nettype wire

// File: rtl/renkon_pkg.sv
`default_nettype none

package renkon_pkg;

  // ====================
  // array sizes
  // ====================

  // cores working in parallel per pass
  localparam int N_CORE   = 4;
  localparam int CORE_LOG = 2;

  // ====================
  // data path widths
  // ====================

  localparam int DWIDTH    = 16;
  // wide enough for a long run of 32-bit products
  localparam int ACC_WIDTH = 40;
  // fraction bits dropped before saturation
  localparam int QBITS     = 8;

  // layer size fields
  localparam int LWIDTH  = 10;

  // memory address widths
  localparam int IMGSIZE = 10;
  localparam int NETSIZE = 8;

  // ====================
  // phase codes
  // ====================

  localparam logic [1:0] S_WAIT    = 2'd0;
  localparam logic [1:0] S_NETWORK = 2'd1;
  localparam logic [1:0] S_INPUT   = 2'd2;
  localparam logic [1:0] S_OUTPUT  = 2'd3;

endpackage

`default_nettype wire

// File: rtl/renkon_serial.sv
`default_nettype none

module renkon_serial
  ( input  wire                                   clk
  , input  wire                                   xrst
  , input  wire                                   res_valid
  , input  wire  signed [renkon_pkg::DWIDTH-1:0]  results [renkon_pkg::N_CORE]
  , input  wire         [renkon_pkg::IMGSIZE-1:0] out_base
  , input  wire         [renkon_pkg::CORE_LOG:0]  n_valid
  , output logic                                  img_we
  , output logic        [renkon_pkg::IMGSIZE-1:0] img_waddr
  , output logic signed [renkon_pkg::DWIDTH-1:0]  img_wdata
  , output logic                                  drain_end
  );

  logic signed [renkon_pkg::DWIDTH-1:0]  res_buf [renkon_pkg::N_CORE];
  logic                                  busy;
  logic        [renkon_pkg::CORE_LOG:0]  idx;
  logic                                  idx_last;

  // ====================
  // capture
  // ====================

  // whole pass taken in one go
  always @(posedge clk)
    if (res_valid)
      for (int c = 0; c < renkon_pkg::N_CORE; c++)
        res_buf[c] <= results[c];

  // ====================
  // drain
  // ====================

  assign idx_last = idx == n_valid - 1'b1;

  always @(posedge clk)
    if (!xrst) begin
      busy <= 1'b0;
      idx  <= '0;
    end
    else if (res_valid) begin
      busy <= 1'b1;
      idx  <= '0;
    end
    else if (busy) begin
      if (idx_last)
        busy <= 1'b0;
      idx <= idx + 1'b1;
    end

  // one word per cycle while busy
  assign img_we    = busy;
  assign img_waddr = out_base
                   + {{(renkon_pkg::IMGSIZE-renkon_pkg::CORE_LOG-1){1'b0}}, idx};
  assign img_wdata = res_buf[idx[renkon_pkg::CORE_LOG-1:0]];

  always @(posedge clk)
    if (!xrst)
      drain_end <= 1'b0;
    else
      drain_end <= busy && idx_last;

endmodule

`default_nettype wire

// File: rtl/renkon_top.sv
`default_nettype none

module renkon_top
  ( input  wire                                   clk
  , input  wire                                   xrst
  , input  wire                                   req
  , input  wire                                   relu_en
  , input  wire         [renkon_pkg::LWIDTH-1:0]  total_in
  , input  wire         [renkon_pkg::LWIDTH-1:0]  total_out
  , input  wire         [renkon_pkg::IMGSIZE-1:0] in_offset
  , input  wire         [renkon_pkg::IMGSIZE-1:0] out_offset
  , input  wire         [renkon_pkg::NETSIZE-1:0] net_offset
  , input  wire                                   net_we
  , input  wire         [renkon_pkg::CORE_LOG-1:0] net_sel
  , input  wire         [renkon_pkg::NETSIZE-1:0] net_addr
  , input  wire  signed [renkon_pkg::DWIDTH-1:0]  net_wdata
  , input  wire                                   img_we
  , input  wire         [renkon_pkg::IMGSIZE-1:0] img_addr
  , input  wire  signed [renkon_pkg::DWIDTH-1:0]  img_wdata
  , input  wire         [renkon_pkg::IMGSIZE-1:0] img_raddr
  , output wire  signed [renkon_pkg::DWIDTH-1:0]  img_rdata
  , output wire                                   ack
  , output wire         [1:0]                     core_state
  );

  wire        [renkon_pkg::NETSIZE-1:0]  net_raddr;
  wire        [renkon_pkg::IMGSIZE-1:0]  ctrl_img_raddr;
  wire signed [renkon_pkg::DWIDTH-1:0]   ctrl_img_rdata;
  wire                                   breg_we;
  wire                                   mac_en;
  wire                                   last_input;
  wire                                   relu;
  wire        [renkon_pkg::IMGSIZE-1:0]  out_base;
  wire        [renkon_pkg::CORE_LOG:0]   n_valid;
  wire                                   drain_end;

  wire signed [renkon_pkg::DWIDTH-1:0]   results    [renkon_pkg::N_CORE];
  wire                                   core_valid [renkon_pkg::N_CORE];

  wire                                   ser_we;
  wire        [renkon_pkg::IMGSIZE-1:0]  ser_waddr;
  wire signed [renkon_pkg::DWIDTH-1:0]   ser_wdata;

  renkon_ctrl ctrl_inst
    ( .clk        (clk)
    , .xrst       (xrst)
    , .req        (req)
    , .relu_en    (relu_en)
    , .total_in   (total_in)
    , .total_out  (total_out)
    , .in_offset  (in_offset)
    , .out_offset (out_offset)
    , .net_offset (net_offset)
    , .drain_end  (drain_end)
    , .ack        (ack)
    , .core_state (core_state)
    , .net_raddr  (net_raddr)
    , .img_raddr  (ctrl_img_raddr)
    , .breg_we    (breg_we)
    , .mac_en     (mac_en)
    , .last_input (last_input)
    , .relu       (relu)
    , .out_base   (out_base)
    , .n_valid    (n_valid)
    );

  // ====================
  // core array
  // ====================

  for (genvar c = 0; c < renkon_pkg::N_CORE; c++) begin : g_core
    renkon_core #(.core_id(renkon_pkg::CORE_LOG'(c))) core_inst
      ( .clk        (clk)
      , .xrst       (xrst)
      , .net_we     (net_we)
      , .net_sel    (net_sel)
      , .net_waddr  (net_addr)
      , .net_wdata  (net_wdata)
      , .net_raddr  (net_raddr)
      , .breg_we    (breg_we)
      , .mac_en     (mac_en)
      , .last_input (last_input)
      , .relu       (relu)
      , .img_rdata  (ctrl_img_rdata)
      , .result     (results[c])
      , .res_valid  (core_valid[c])
      );
  end

  // cores run in lockstep, core 0 speaks for all
  renkon_serial serial_inst
    ( .clk       (clk)
    , .xrst      (xrst)
    , .res_valid (core_valid[0])
    , .results   (results)
    , .out_base  (out_base)
    , .n_valid   (n_valid)
    , .img_we    (ser_we)
    , .img_waddr (ser_waddr)
    , .img_wdata (ser_wdata)
    , .drain_end (drain_end)
    );

  renkon_img_mem img_mem_inst
    ( .clk        (clk)
    , .raddr      (ctrl_img_raddr)
    , .host_raddr (img_raddr)
    , .we         (ser_we)
    , .waddr      (ser_waddr)
    , .wdata      (ser_wdata)
    , .host_we    (img_we)
    , .host_waddr (img_addr)
    , .host_wdata (img_wdata)
    , .rdata      (ctrl_img_rdata)
    , .host_rdata (img_rdata)
    );

endmodule

`default_nettype wire
